// ==== src/soundPkg.sv ====
// Sound path definitions
// Sample format and default gain factors shared by the cartridge sound
// mixer and its gain stages

`default_nettype none

package soundPkg;

    // Sample format of every source and every gain stage output
    localparam int SoundWidth = 16;

    typedef logic signed [SoundWidth-1:0] sampleT;

    // Gain stage arithmetic, factor 16 is unity
    localparam int GainShift    = 4;
    localparam int GainMulWidth = 6;    // Signed, non-negative factors only

    // External mix gains
    localparam logic signed [GainMulWidth-1:0] ExtMegaromMul = GainMulWidth'(12);
    localparam logic signed [GainMulWidth-1:0] ExtFmMul      = GainMulWidth'(16);
    localparam logic signed [GainMulWidth-1:0] ExtPsgMul     = GainMulWidth'(8);

    // Cartridge connector mix gains
    localparam logic signed [GainMulWidth-1:0] IntMegaromMul = GainMulWidth'(16);
    localparam logic signed [GainMulWidth-1:0] IntFmMul      = GainMulWidth'(10);

endpackage

`default_nettype wire

// ==== src/soundAttenuator.sv ====
// Sound gain stage
// Multiplies each sample by a fixed factor, shifts it right arithmetically
// and clips it to the sample range. One cycle of latency

`default_nettype none
`timescale 1ns/10ps

module soundAttenuator
    import soundPkg::*;
#(
    parameter logic signed [GainMulWidth-1:0] Mul   = GainMulWidth'(1 << GainShift),
    parameter int                             Shift = GainShift
) (
    input  wire    CLK,
    input  wire    RESET_n,
    input  sampleT sampleIn,
    output sampleT sampleOut
);

    localparam int ProdWidth = SoundWidth + GainMulWidth;

    // Sample range limits, sign extended to the product width
    localparam logic signed [ProdWidth-1:0] ProdMax =
        {{(GainMulWidth + 1){1'b0}}, {(SoundWidth - 1){1'b1}}};
    localparam logic signed [ProdWidth-1:0] ProdMin =
        {{(GainMulWidth + 1){1'b1}}, {(SoundWidth - 1){1'b0}}};

    logic signed [ProdWidth-1:0] product;
    logic signed [ProdWidth-1:0] scaled;
    sampleT                      clipped;

    assign product = sampleIn * Mul;      // Full width, cannot overflow
    assign scaled  = product >>> Shift;   // Rounds toward minus infinity

    always_comb begin
        if (scaled > ProdMax) begin
            clipped = ProdMax[SoundWidth-1:0];
        end else if (scaled < ProdMin) begin
            clipped = ProdMin[SoundWidth-1:0];
        end else begin
            clipped = scaled[SoundWidth-1:0];
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            sampleOut <= '0;
        end else begin
            sampleOut <= clipped;
        end
    end

    // Silence in gives silence out on the next sample
    zeroInZeroOut: assert property (
        @(posedge CLK) disable iff (!RESET_n)
        (sampleIn == '0) |=> (sampleOut == '0)
    );

endmodule

`default_nettype wire

// ==== src/soundMixer.sv ====
// Sound mixer
// Registered sum of Count samples. The full width sum is clipped to the
// output range when the output is narrower, otherwise left justified

`default_nettype none
`timescale 1ns/10ps

module soundMixer
    import soundPkg::*;
#(
    parameter int Count    = 2,
    parameter int OutWidth = 16
) (
    input  wire                         CLK,
    input  wire                         RESET_n,
    input  sampleT [Count-1:0]          samples,
    output logic signed [OutWidth-1:0]  mix
);

    // Headroom so the sum never wraps
    localparam int SumWidth = SoundWidth + $clog2(Count);

    logic signed [SumWidth-1:0] sum;
    logic signed [OutWidth-1:0] mixNext;

    always_comb begin
        sum = '0;
        for (int i = 0; i < Count; i++) begin
            sum = sum + $signed(samples[i]);    // Sign extended to SumWidth
        end
    end

    generate
        if (OutWidth < SumWidth) begin : gClip
            // Output range limits at the sum width
            localparam logic signed [SumWidth-1:0] LimitHi =
                {{(SumWidth - OutWidth + 1){1'b0}}, {(OutWidth - 1){1'b1}}};
            localparam logic signed [SumWidth-1:0] LimitLo =
                {{(SumWidth - OutWidth + 1){1'b1}}, {(OutWidth - 1){1'b0}}};
            localparam logic signed [OutWidth-1:0] OutMax = LimitHi[OutWidth-1:0];
            localparam logic signed [OutWidth-1:0] OutMin = LimitLo[OutWidth-1:0];

            always_comb begin
                if (sum > LimitHi) begin
                    mixNext = OutMax;
                end else if (sum < LimitLo) begin
                    mixNext = OutMin;
                end else begin
                    mixNext = sum[OutWidth-1:0];
                end
            end

            // An overdriven sum must reach the output as the rail value
            clipHigh: assert property (
                @(posedge CLK) disable iff (!RESET_n)
                (sum > LimitHi) |=> (mix == OutMax)
            );

            clipLow: assert property (
                @(posedge CLK) disable iff (!RESET_n)
                (sum < LimitLo) |=> (mix == OutMin)
            );
        end else begin : gWiden
            // Top bit of the sum lands on the top output bit
            assign mixNext = {sum, {(OutWidth - SumWidth){1'b0}}};
        end
    endgenerate

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            mix <= '0;
        end else begin
            mix <= mixNext;
        end
    end

endmodule

`default_nettype wire

// ==== src/cartridgeSoundMixer.sv ====
// Cartridge sound mixer
// Attenuates the mega-ROM, FM and PSG sources and builds the external mix
// and the cartridge connector mix. FM reaches the connector only when enabled

`default_nettype none
`timescale 1ns/10ps

module cartridgeSoundMixer
    import soundPkg::*;
#(
    parameter int                             OutWidth         = 16,
    parameter logic signed [GainMulWidth-1:0] ExtMegaromGain   = ExtMegaromMul,
    parameter logic signed [GainMulWidth-1:0] ExtFmGain        = ExtFmMul,
    parameter logic signed [GainMulWidth-1:0] ExtPsgGain       = ExtPsgMul,
    parameter logic signed [GainMulWidth-1:0] IntMegaromGain   = IntMegaromMul,
    parameter logic signed [GainMulWidth-1:0] IntFmGain        = IntFmMul
) (
    input  wire                         CLK,
    input  wire                         RESET_n,
    input  sampleT                      megaromSound,
    input  sampleT                      fmSound,
    input  sampleT                      psgSound,
    input  wire                         fmOutputEnable,  // FM to cartridge connector
    output logic signed [OutWidth-1:0]  externalSound,
    output logic signed [OutWidth-1:0]  internalSound
);

    // Mixer input slots
    localparam int ExtMegarom = 0;
    localparam int ExtFm      = 1;
    localparam int ExtPsg     = 2;
    localparam int ExtCount   = 3;

    localparam int IntMegarom = 0;
    localparam int IntFm      = 1;
    localparam int IntCount   = 2;

    sampleT                 fmIntSound;
    sampleT [ExtCount-1:0]  extSamples;
    sampleT [IntCount-1:0]  intSamples;

    // Gated ahead of the gain stage so the enable shares the sample latency
    assign fmIntSound = fmOutputEnable ? fmSound : '0;

    // External path
    soundAttenuator #(
        .Mul        (ExtMegaromGain),
        .Shift      (GainShift)
    ) attExtMegarom (
        .CLK,
        .RESET_n,
        .sampleIn   (megaromSound),
        .sampleOut  (extSamples[ExtMegarom])
    );

    soundAttenuator #(
        .Mul        (ExtFmGain),
        .Shift      (GainShift)
    ) attExtFm (
        .CLK,
        .RESET_n,
        .sampleIn   (fmSound),          // Always audible outside
        .sampleOut  (extSamples[ExtFm])
    );

    soundAttenuator #(
        .Mul        (ExtPsgGain),
        .Shift      (GainShift)
    ) attExtPsg (
        .CLK,
        .RESET_n,
        .sampleIn   (psgSound),
        .sampleOut  (extSamples[ExtPsg])
    );

    // Cartridge connector path, no PSG here
    soundAttenuator #(
        .Mul        (IntMegaromGain),
        .Shift      (GainShift)
    ) attIntMegarom (
        .CLK,
        .RESET_n,
        .sampleIn   (megaromSound),
        .sampleOut  (intSamples[IntMegarom])
    );

    soundAttenuator #(
        .Mul        (IntFmGain),
        .Shift      (GainShift)
    ) attIntFm (
        .CLK,
        .RESET_n,
        .sampleIn   (fmIntSound),
        .sampleOut  (intSamples[IntFm])
    );

    soundMixer #(
        .Count      (ExtCount),
        .OutWidth   (OutWidth)
    ) mixExt (
        .CLK,
        .RESET_n,
        .samples    (extSamples),
        .mix        (externalSound)
    );

    soundMixer #(
        .Count      (IntCount),
        .OutWidth   (OutWidth)
    ) mixInt (
        .CLK,
        .RESET_n,
        .samples    (intSamples),
        .mix        (internalSound)
    );

endmodule

`default_nettype wire

// ==== verif/tbClock.sv ====
// Testbench clock generator
// Free running clock that starts low, one full period per Period ns

`default_nettype none
`timescale 1ns/10ps

module tbClock #(
    parameter int Period = 100    // ns
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever begin
            #(Period / 2);
            CLK = ~CLK;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tbCartridgeSoundMixer.sv ====
// Cartridge sound mixer testbench
// Drives random and directed samples into the mixer and checks both mixes
// against a two cycle reference model with concurrent assertions

`default_nettype none
`timescale 1ns/10ps

module tbCartridgeSoundMixer
    import soundPkg::*;
();

    localparam int OutWidth    = 16;
    localparam int ClockPeriod = 100;
    localparam int InputDelay  = 10;
    localparam int ResetCycles = 10;
    localparam int TestCycles  = 2000;
    localparam int SlackCycles = 50;
    localparam int TimeoutNs   = (ResetCycles + TestCycles + SlackCycles) * ClockPeriod;

    // Stimulus phases, together TestCycles
    localparam int RandomCycles    = 1000;
    localparam int EnableLowCycles = 300;
    localparam int ToggleCycles    = 450;
    localparam int FullScaleCycles = 100;   // Per polarity
    localparam int SilenceCycles   = 50;

    localparam int SampleMax = (1 << (SoundWidth - 1)) - 1;
    localparam int SampleMin = -(1 << (SoundWidth - 1));

    logic                       CLK;
    logic                       RESET_n;
    sampleT                     megaromSound;
    sampleT                     fmSound;
    sampleT                     psgSound;
    logic                       fmOutputEnable;
    logic signed [OutWidth-1:0] externalSound;
    logic signed [OutWidth-1:0] internalSound;

    integer seed;

    // Inputs as sampled one and two edges ago
    sampleT megHist1;
    sampleT megHist2;
    sampleT fmHist1;
    sampleT fmHist2;
    sampleT psgHist1;
    sampleT psgHist2;
    logic   enHist1;
    logic   enHist2;

    logic signed [OutWidth-1:0] expExt;
    logic signed [OutWidth-1:0] expInt;
    logic signed [OutWidth-1:0] expIntMegOnly;   // Connector mix with FM gated off

    tbClock #(.Period(ClockPeriod)) clockGen (.CLK);

    cartridgeSoundMixer #(.OutWidth(OutWidth)) i_dut (
        .CLK,
        .RESET_n,
        .megaromSound,
        .fmSound,
        .psgSound,
        .fmOutputEnable,
        .externalSound,
        .internalSound
    );

    // Sample times factor, arithmetic shift right, clip to the sample range
    function automatic int gainRule(input sampleT sample, input int mul);
        int product;
        int scaled;
        product = int'(sample) * mul;
        scaled  = product >>> GainShift;
        if (scaled > SampleMax) begin
            return SampleMax;
        end
        if (scaled < SampleMin) begin
            return SampleMin;
        end
        return scaled;
    endfunction

    // Clip when the output is narrower than the full sum, else left justify
    function automatic logic signed [OutWidth-1:0] mixRule(input int sum, input int count);
        int     fullWidth;
        longint limitHi;
        longint limitLo;
        longint result;
        fullWidth = SoundWidth + $clog2(count);
        limitHi   = (longint'(1) << (OutWidth - 1)) - 1;
        limitLo   = -(longint'(1) << (OutWidth - 1));
        if (OutWidth < fullWidth) begin
            result = sum;
            if (result > limitHi) begin
                result = limitHi;
            end else if (result < limitLo) begin
                result = limitLo;
            end
        end else begin
            result = longint'(sum) << (OutWidth - fullWidth);
        end
        return result[OutWidth-1:0];
    endfunction

    always @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            megHist1 <= '0;
            megHist2 <= '0;
            fmHist1  <= '0;
            fmHist2  <= '0;
            psgHist1 <= '0;
            psgHist2 <= '0;
            enHist1  <= 1'b0;
            enHist2  <= 1'b0;
        end else begin
            megHist1 <= megaromSound;
            megHist2 <= megHist1;
            fmHist1  <= fmSound;
            fmHist2  <= fmHist1;
            psgHist1 <= psgSound;
            psgHist2 <= psgHist1;
            enHist1  <= fmOutputEnable;
            enHist2  <= enHist1;
        end
    end

    always_comb begin
        int fmInt;
        fmInt         = enHist2 ? gainRule(fmHist2, IntFmMul) : 0;
        expExt        = mixRule(gainRule(megHist2, ExtMegaromMul) + gainRule(fmHist2, ExtFmMul)
                                + gainRule(psgHist2, ExtPsgMul), 3);
        expInt        = mixRule(gainRule(megHist2, IntMegaromMul) + fmInt, 2);
        expIntMegOnly = mixRule(gainRule(megHist2, IntMegaromMul), 2);
    end

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // Next sample set, 10 ns after the rising edge
    task automatic driveSources(input sampleT meg, input sampleT fm, input sampleT psg,
                                input logic en);
        @(posedge CLK);
        #InputDelay;
        megaromSound   = meg;
        fmSound        = fm;
        psgSound       = psg;
        fmOutputEnable = en;
    endtask

    quietInReset: assert property (@(posedge CLK)
        !RESET_n |-> (externalSound == '0 && internalSound == '0))
        else stopOnError($sformatf(
            "ERROR: in reset externalSound expected 0 actual %h, internalSound expected 0 actual %h",
            $sampled(externalSound), $sampled(internalSound)));

    extMatch: assert property (@(posedge CLK) externalSound == expExt)
        else stopOnError($sformatf("ERROR: externalSound expected %h actual %h",
            $sampled(expExt), $sampled(externalSound)));

    intMatch: assert property (@(posedge CLK) internalSound == expInt)
        else stopOnError($sformatf("ERROR: internalSound expected %h actual %h",
            $sampled(expInt), $sampled(internalSound)));

    // FM gated off leaves only the mega-ROM share on the connector
    intFmGated: assert property (@(posedge CLK) disable iff (!RESET_n)
        !enHist2 |-> (internalSound == expIntMegOnly))
        else stopOnError($sformatf("ERROR: internalSound (FM off) expected %h actual %h",
            $sampled(expIntMegOnly), $sampled(internalSound)));

    initial begin
        #(TimeoutNs);
        stopOnError("Timeout: the stimulus did not finish within the expected run time");
    end

    initial begin
        seed           = 32'h1936e8e5;
        megaromSound   = sampleT'(SampleMax);   // Live sources while the pipeline is held clear
        fmSound        = sampleT'(SampleMax);
        psgSound       = sampleT'(SampleMax);
        fmOutputEnable = 1'b1;
        RESET_n        = 1'b1;
        #1;
        RESET_n = 1'b0;           // Clean falling edge for the async reset
        repeat (ResetCycles) @(posedge CLK);
        #InputDelay;
        RESET_n = 1'b1;

        // Random samples with FM on the connector
        repeat (RandomCycles) begin
            driveSources(sampleT'($random(seed)), sampleT'($random(seed)),
                         sampleT'($random(seed)), 1'b1);
        end

        // FM held off the connector
        repeat (EnableLowCycles) begin
            driveSources(sampleT'($random(seed)), sampleT'($random(seed)),
                         sampleT'($random(seed)), 1'b0);
        end

        // Enable toggling at random
        repeat (ToggleCycles) begin
            driveSources(sampleT'($random(seed)), sampleT'($random(seed)),
                         sampleT'($random(seed)), 1'($random(seed)));
        end

        // Full scale drives both mixes into the clip
        repeat (FullScaleCycles) begin
            driveSources(sampleT'(SampleMax), sampleT'(SampleMax), sampleT'(SampleMax), 1'b1);
        end
        repeat (FullScaleCycles) begin
            driveSources(sampleT'(SampleMin), sampleT'(SampleMin), sampleT'(SampleMin), 1'b1);
        end

        repeat (SilenceCycles) begin
            driveSources('0, '0, '0, 1'b1);
        end

        // Let the last samples leave the pipeline and the last checks settle
        repeat (3) @(posedge CLK);
        #InputDelay;
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cartridgeSoundMixer.f ====
src/soundPkg.sv
src/soundAttenuator.sv
src/soundMixer.sv
src/cartridgeSoundMixer.sv
verif/tbClock.sv
verif/tbCartridgeSoundMixer.sv

// ==== run.sh ====
#!/bin/sh
# Builds the cartridge sound mixer testbench with Verilator and runs it.
# The result is taken from the pass line in the simulation output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbCartridgeSoundMixer \
    -f cartridgeSoundMixer.f \
    --Mdir obj_dir -o simCartridgeSoundMixer

status=0
simOutput=$(./obj_dir/simCartridgeSoundMixer 2>&1) || status=$?
printf '%s\n' "$simOutput"

if printf '%s\n' "$simOutput" | grep -qx '>>> PASS'; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed (exit status $status)"
exit 1
